// ==== hdl/rvDecodePkg.sv ====
`default_nettype none

package rvDecodePkg;

    localparam int xLen     = 32;  // RV32 data and address width
    localparam int regAddrW = 5;

    // major opcodes
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    localparam logic [3:0] aluAdd  = 4'd0;
    localparam logic [3:0] aluSub  = 4'd1;
    localparam logic [3:0] aluSll  = 4'd2;
    localparam logic [3:0] aluSlt  = 4'd3;
    localparam logic [3:0] aluSltu = 4'd4;
    localparam logic [3:0] aluXor  = 4'd5;
    localparam logic [3:0] aluSrl  = 4'd6;
    localparam logic [3:0] aluSra  = 4'd7;
    localparam logic [3:0] aluOr   = 4'd8;
    localparam logic [3:0] aluAnd  = 4'd9;

    localparam logic [2:0] fnAlu  = 3'd0;  // writeback source
    localparam logic [2:0] fnMem  = 3'd1;
    localparam logic [2:0] fnPc4  = 3'd2;
    localparam logic [2:0] fnUimm = 3'd3;
    localparam logic [2:0] fnMul  = 3'd4;  // M-extension unit result

    localparam logic [1:0] pcSeq    = 2'd0;
    localparam logic [1:0] pcBranch = 2'd1;
    localparam logic [1:0] pcJal    = 2'd2;
    localparam logic [1:0] pcJalr   = 2'd3;

    localparam logic [1:0] bRs2  = 2'd0;  // operand b source
    localparam logic [1:0] bIImm = 2'd1;
    localparam logic [1:0] bSImm = 2'd2;

    typedef struct packed {logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} rFmt_t;
    typedef struct packed {logic [11:0] imm; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;} iFmt_t;
    typedef struct packed {logic [6:0] imm11_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] imm4_0; logic [6:0] opcode;} sFmt_t;
    typedef struct packed {logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;} bFmt_t;
    typedef struct packed {logic [19:0] imm31_12; logic [4:0] rd; logic [6:0] opcode;} uFmt_t;
    typedef struct packed {logic imm20; logic [9:0] imm10_1; logic imm11;
        logic [7:0] imm19_12; logic [4:0] rd; logic [6:0] opcode;} jFmt_t;

    typedef union packed {rFmt_t r; iFmt_t i; sFmt_t s; bFmt_t b; uFmt_t u; jFmt_t j;} rvInstr_u;

    typedef struct packed {
        logic regWe, bneq, btype, jr, j, lui, auipc, illegal;
        logic [2:0] fn;
        logic [1:0] bSel;
        logic [3:0] aluFn;
        logic [1:0] pcSelect;
        logic [3:0] memOp;     // {load, store, size}
        logic [2:0] mOp;
    } ctrlBundle_t;

    typedef struct packed {logic [xLen-1:0] iImm, sImm, bImm, uImm, jImm;} immSet_t;

    typedef struct packed {
        ctrlBundle_t ctrl;
        immSet_t imm;
        logic [xLen-1:0] pc;
        logic [regAddrW-1:0] rs1, rs2, rd, shamt;
    } decodeOut_t;

endpackage

`default_nettype wire

// ==== hdl/controlDecoder.sv ====
`default_nettype none

module controlDecoder
    import rvDecodePkg::*;
(
    input  rvInstr_u    instr,
    output ctrlBundle_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;          // instruction bit 30

    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;
    assign alt    = instr.r.funct7[5];

    // shared by OP and OP-IMM
    function automatic logic [3:0] aluFromFunct3(input logic [2:0] f3, input logic altFn);
        logic [3:0] fnSel;
        case (f3)
            3'b000:  fnSel = altFn ? aluSub : aluAdd;
            3'b001:  fnSel = aluSll;
            3'b010:  fnSel = aluSlt;
            3'b011:  fnSel = aluSltu;
            3'b100:  fnSel = aluXor;
            3'b101:  fnSel = altFn ? aluSra : aluSrl;
            3'b110:  fnSel = aluOr;
            default: fnSel = aluAnd;
        endcase
        return fnSel;
    endfunction

    always_comb
    begin
        ctrl          = '0;
        ctrl.fn       = fnAlu;
        ctrl.bSel     = bRs2;
        ctrl.aluFn    = aluAdd;
        ctrl.pcSelect = pcSeq;

        case (opcode)
            opOp:
            begin
                ctrl.regWe = 1'b1;
                ctrl.aluFn = aluFromFunct3(funct3, alt);
                if (funct7 == 7'b0000001)
                begin
                    ctrl.fn  = fnMul;     // mul/div group
                    ctrl.mOp = funct3;
                end
            end
            opOpImm:
            begin
                ctrl.regWe = 1'b1;
                ctrl.bSel  = bIImm;
                // bit 30 is immediate data except on right shifts
                ctrl.aluFn = aluFromFunct3(funct3, alt && (funct3 == 3'b101));
            end
            opLoad:
            begin
                ctrl.regWe = 1'b1;
                ctrl.bSel  = bIImm;
                ctrl.fn    = fnMem;
                ctrl.memOp = {2'b10, funct3[1:0]};
            end
            opStore:
            begin
                ctrl.bSel  = bSImm;
                ctrl.memOp = {2'b01, funct3[1:0]};
            end
            opBranch:
            begin
                ctrl.btype    = 1'b1;
                ctrl.pcSelect = pcBranch;
                case (funct3)
                    3'b001:
                    begin
                        ctrl.aluFn = aluSub;  // bne
                        ctrl.bneq  = 1'b1;
                    end
                    3'b100:
                    begin
                        ctrl.aluFn = aluSlt;  // blt
                        ctrl.bneq  = 1'b1;
                    end
                    3'b101:  ctrl.aluFn = aluSlt;   // bge
                    3'b110:
                    begin
                        ctrl.aluFn = aluSltu; // bltu
                        ctrl.bneq  = 1'b1;
                    end
                    3'b111:  ctrl.aluFn = aluSltu;  // bgeu
                    default: ctrl.aluFn = aluSub;   // beq
                endcase
            end
            opJal:
            begin
                ctrl.j        = 1'b1;
                ctrl.regWe    = 1'b1;
                ctrl.fn       = fnPc4;
                ctrl.pcSelect = pcJal;
            end
            opJalr:
            begin
                ctrl.jr       = 1'b1;
                ctrl.regWe    = 1'b1;
                ctrl.fn       = fnPc4;
                ctrl.bSel     = bIImm;   // target is rs1 + iImm
                ctrl.pcSelect = pcJalr;
            end
            opLui:
            begin
                ctrl.lui   = 1'b1;
                ctrl.regWe = 1'b1;
                ctrl.fn    = fnUimm;
            end
            opAuipc:
            begin
                ctrl.auipc = 1'b1;
                ctrl.regWe = 1'b1;  // pc + uImm through the alu
            end
            default:
            begin
                ctrl.illegal = 1'b1;  // includes system, fence and opcode zero
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`default_nettype none

module decodeStage
    import rvDecodePkg::*;
(
    input  logic            clk,
    input  logic            nrst,
    input  logic [xLen-1:0] instr,
    input  logic [xLen-1:0] pc,
    output decodeOut_t      dec
);

    rvInstr_u        instrQ;   // held instruction word
    logic [xLen-1:0] pcQ;
    ctrlBundle_t     ctrl;
    immSet_t         imm;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            instrQ <= '0;     // opcode zero decodes as illegal
            pcQ    <= '0;
        end
        else
        begin
            instrQ <= instr;
            pcQ    <= pc;
        end
    end

    controlDecoder i_controlDecoder (
        .instr (instrQ),
        .ctrl  (ctrl)
    );

    always_comb
    begin
        imm.iImm = {{20{instrQ.i.imm[11]}}, instrQ.i.imm};
        imm.sImm = {{20{instrQ.s.imm11_5[6]}}, instrQ.s.imm11_5, instrQ.s.imm4_0};
        imm.bImm = {{19{instrQ.b.imm12}}, instrQ.b.imm12, instrQ.b.imm11,
                    instrQ.b.imm10_5, instrQ.b.imm4_1, 1'b0};
        imm.uImm = {instrQ.u.imm31_12, 12'b0};
        imm.jImm = {{11{instrQ.j.imm20}}, instrQ.j.imm20, instrQ.j.imm19_12,
                    instrQ.j.imm11, instrQ.j.imm10_1, 1'b0};
    end

    always_comb
    begin
        dec.ctrl  = ctrl;
        dec.imm   = imm;
        dec.pc    = pcQ;
        dec.rs1   = instrQ.r.rs1;
        dec.rs2   = instrQ.r.rs2;
        dec.rd    = instrQ.r.rd;
        dec.shamt = instrQ.i.imm[4:0];  // low bits of the I immediate
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile
    import rvDecodePkg::*;
#(
    parameter int regCount = 32    // 16 for RV32E
)
(
    input  logic                clk,
    input  logic                nrst,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    output logic [xLen-1:0]     rs1Data,
    output logic [xLen-1:0]     rs2Data,
    input  logic                wbEn,
    input  logic [regAddrW-1:0] wbAddr,
    input  logic [xLen-1:0]     wbData
);

    logic [xLen-1:0] regs [regCount];
    logic            wbValid;    // write that actually lands in the array

    assign wbValid = wbEn && (wbAddr != '0) && (int'(wbAddr) < regCount);

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int k = 0; k < regCount; k++)
                regs[k] <= '0;
        end
        else if (wbValid)
            regs[wbAddr] <= wbData;
    end

    // x0 and addresses past the array read zero, a pending write is bypassed
    function automatic logic [xLen-1:0] readPort(input logic [regAddrW-1:0] addr);
        logic [xLen-1:0] val;
        if (addr == '0 || int'(addr) >= regCount)
            val = '0;
        else if (wbValid && addr == wbAddr)
            val = wbData;
        else
            val = regs[addr];
        return val;
    endfunction

    always_comb
    begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

endmodule

`default_nettype wire

// ==== hdl/decodeUnit.sv ====
`default_nettype none

module decodeUnit
    import rvDecodePkg::*;
#(
    parameter int regCount = 32
)
(
    input  logic                clk,
    input  logic                nrst,
    input  logic [xLen-1:0]     instr,      // from fetch
    input  logic [xLen-1:0]     pc,
    input  logic                wbEn,       // writeback port
    input  logic [regAddrW-1:0] wbAddr,
    input  logic [xLen-1:0]     wbData,
    output decodeOut_t          dec,
    output logic [xLen-1:0]     rs1Data,
    output logic [xLen-1:0]     rs2Data
);

    decodeStage i_decodeStage (
        .clk   (clk),
        .nrst  (nrst),
        .instr (instr),
        .pc    (pc),
        .dec   (dec)
    );

    // operand addresses come straight from the held instruction
    regFile #(
        .regCount (regCount)
    ) i_regFile (
        .clk     (clk),
        .nrst    (nrst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

endmodule

`default_nettype wire

// ==== sim/decodeUnit_checker.sv ====
`default_nettype none

module decodeUnit_checker
    import rvDecodePkg::*;
(
    input logic            clk,
    input logic            nrst,
    input decodeOut_t      dec,
    input logic [xLen-1:0] rs1Data
);

    int   failCount = 0;
    logic anyClass;   // some known instruction class decoded

    assign anyClass = dec.ctrl.regWe || dec.ctrl.btype || dec.ctrl.j || dec.ctrl.jr
                   || dec.ctrl.lui || dec.ctrl.auipc || dec.ctrl.memOp[3] || dec.ctrl.memOp[2];

    illegalAlone: assert property (@(posedge clk) disable iff (!nrst)
        dec.ctrl.illegal == !anyClass)
    else
    begin
        failCount++;
        $error("illegal flag disagrees with the class flags");
    end

    zeroReg: assert property (@(posedge clk) disable iff (!nrst)
        (dec.rs1 == '0) |-> (rs1Data == '0))
    else
    begin
        failCount++;
        $error("x0 read returned a nonzero value");
    end

    quietAfterReset: assert property (@(posedge clk)
        $rose(nrst) |-> (!dec.ctrl.regWe && dec.ctrl.memOp[3:2] == 2'b00))
    else
    begin
        failCount++;
        $error("write or memory access enabled right after reset");
    end

endmodule

bind decodeUnit decodeUnit_checker i_checker (
    .clk     (clk),
    .nrst    (nrst),
    .dec     (dec),
    .rs1Data (rs1Data)
);

`default_nettype wire

// ==== sim/decodeUnitTb.sv ====
`default_nettype none

module decodeUnitTb
    import rvDecodePkg::*;
();

    localparam int caseCount = 40;
    localparam int clkPeriod = 40;
    localparam int maxTime   = (caseCount + 100) * clkPeriod * 4;

    logic                clk;
    logic                nrst;
    logic [xLen-1:0]     instr;
    logic [xLen-1:0]     pc;
    logic                wbEn;
    logic [regAddrW-1:0] wbAddr;
    logic [xLen-1:0]     wbData;
    decodeOut_t          dec;
    logic [xLen-1:0]     rs1Data;
    logic [xLen-1:0]     rs2Data;

    logic [31:0]     caseMem [3*caseCount];  // instr, pc, ctrl per case
    logic [xLen-1:0] regModel [32];
    logic [15:0]     lfsrState;
    int              checks = 0;
    int              errors = 0;
    int              total;

    decodeUnit #(
        .regCount (32)
    ) i_decodeUnit (
        .clk     (clk),
        .nrst    (nrst),
        .instr   (instr),
        .pc      (pc),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic drawWord(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsrState = lfsrNext(lfsrState);  // one step per bit
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] iImmOf(input logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] sImmOf(input logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] bImmOf(input logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] uImmOf(input logic [31:0] w);
        return {w[31:12], 12'b0};
    endfunction

    function automatic logic [31:0] jImmOf(input logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // add rd, rs1, rs2 used only to steer the read ports
    function automatic logic [31:0] addInstr(input int src1, input int src2, input int dst);
        return {7'b0000000, 5'(src2), 5'(src1), 3'b000, 5'(dst), opOp};
    endfunction

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic reportTest(input string name, input int checkStart, input int errStart);
        $display("test %-12s %0d checks, %0d errors", name, checks - checkStart,
                 errors - errStart);
    endtask

    task automatic verifyResetState(input string phase);
        compareWord({phase, " illegal"}, 32'(dec.ctrl.illegal), 32'd1);
        compareWord({phase, " regWe"}, 32'(dec.ctrl.regWe), 32'd0);
        compareWord({phase, " load/store"}, 32'(dec.ctrl.memOp[3:2]), 32'd0);
        compareWord({phase, " rs1Data"}, rs1Data, 32'd0);
        compareWord({phase, " rs2Data"}, rs2Data, 32'd0);
    endtask

    task automatic matchCase(input int idx);
        logic [31:0] w;
        string       tag;
        w   = caseMem[3*idx];
        tag = $sformatf("case %0d (%h)", idx, w);
        compareWord({tag, " ctrl"}, 32'(dec.ctrl), caseMem[3*idx+2]);
        compareWord({tag, " pc"}, dec.pc, caseMem[3*idx+1]);
        compareWord({tag, " rs1"}, 32'(dec.rs1), 32'(w[19:15]));
        compareWord({tag, " rs2"}, 32'(dec.rs2), 32'(w[24:20]));
        compareWord({tag, " rd"}, 32'(dec.rd), 32'(w[11:7]));
        compareWord({tag, " shamt"}, 32'(dec.shamt), 32'(w[24:20]));
        compareWord({tag, " iImm"}, dec.imm.iImm, iImmOf(w));
        compareWord({tag, " sImm"}, dec.imm.sImm, sImmOf(w));
        compareWord({tag, " bImm"}, dec.imm.bImm, bImmOf(w));
        compareWord({tag, " uImm"}, dec.imm.uImm, uImmOf(w));
        compareWord({tag, " jImm"}, dec.imm.jImm, jImmOf(w));
    endtask

    task automatic resetPhase();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        repeat (3) @(negedge clk);
        verifyResetState("in reset");
        @(negedge clk);
        nrst = 1'b1;                          // fourth cycle done
        verifyResetState("after release");
        reportTest("reset", c0, e0);
    endtask

    // one case per cycle, each checked one cycle after it is driven
    task automatic streamCases();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        for (int i = 0; i <= caseCount; i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
                matchCase(i - 1);
            end
            if (i < caseCount)
            begin
                instr = caseMem[3*i];
                pc    = caseMem[3*i+1];
            end
        end
        reportTest("decode", c0, e0);
    endtask

    task automatic regReadback();
        int c0;
        int e0;
        c0 = checks;
        e0 = errors;
        instr = addInstr(0, 0, 0);
        for (int r = 0; r < 32; r++)
        begin
            wbEn   = 1'b1;
            wbAddr = regAddrW'(r);
            drawWord(wbData);
            if (r != 0)
                regModel[r] = wbData;         // x0 keeps zero
            @(negedge clk);
        end
        wbEn = 1'b0;
        for (int r = 0; r <= 32; r++)
        begin
            if (r > 0)
            begin
                @(negedge clk);
                compareWord($sformatf("x%0d via rs1", r - 1), rs1Data, regModel[r-1]);
                compareWord($sformatf("x%0d via rs2", 32 - r), rs2Data, regModel[32-r]);
            end
            if (r < 32)
                instr = addInstr(r, 31 - r, 1);
        end
        reportTest("regfile", c0, e0);
    endtask

    task automatic forwardWrites();
        int          c0;
        int          e0;
        int          fwdRegs [4];
        int          r;
        logic [31:0] expVal;
        c0      = checks;
        e0      = errors;
        fwdRegs = '{5, 0, 31, 12};
        for (int k = 0; k < 4; k++)
        begin
            r     = fwdRegs[k];
            instr = addInstr(r, r, 2);
            @(negedge clk);                   // reader now held
            wbEn   = 1'b1;
            wbAddr = regAddrW'(r);
            drawWord(wbData);
            #(clkPeriod / 4);
            expVal = (r == 0) ? 32'd0 : wbData;
            compareWord($sformatf("bypass x%0d rs1", r), rs1Data, expVal);
            compareWord($sformatf("bypass x%0d rs2", r), rs2Data, expVal);
            if (r != 0)
                regModel[r] = wbData;
            @(negedge clk);
            wbEn = 1'b0;
            #(clkPeriod / 4);
            compareWord($sformatf("stored x%0d", r), rs1Data, regModel[r]);
            @(negedge clk);
        end
        reportTest("forwarding", c0, e0);
    endtask

    initial
    begin
        #(maxTime);
        $display("watchdog: run still going after %0d time units", maxTime);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        nrst      = 1'b0;
        instr     = '0;
        pc        = '0;
        wbEn      = 1'b0;
        wbAddr    = '0;
        wbData    = '0;
        lfsrState = 16'd1549;
        for (int k = 0; k < 32; k++)
            regModel[k] = '0;
        $readmemh("sim/decodeCases.mem", caseMem);

        resetPhase();
        streamCases();
        regReadback();
        forwardWrites();

        total = errors + i_decodeUnit.i_checker.failCount;
        $display("summary: 4 tests, %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_decodeUnit.i_checker.failCount);
        if (total == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/decodeCases.mem ====
// columns: instruction  pc  expected ctrlBundle_t (26 bits, zero extended)
// R/M ops, OP-IMM, loads, stores, branches, jumps, lui, auipc, then illegal words
002081B3 80000000 02000000
407302B3 80000004 02000200
00A49433 80000008 02000400
00D625B3 8000000C 02000600
0107B733 80000010 02000800
013948B3 80000014 02000A00
016ADA33 80000018 02000C00
419C5BB3 8000001C 02000E00
01CDED33 80000020 02001000
01FF7EB3 80000024 02001200
023100B3 80000028 02020000
02629233 8000002C 02020401
029443B3 80000030 02020A04
02C5F533 80000034 02021207
FFB10093 80000038 02002000
40020193 8000003C 02002000
FFF32293 80000040 02002600
7FF44393 80000044 02002A00
00351493 80000048 02002400
41F65593 8000004C 02002E00
00775693 80000050 02002C00
F0087793 80000054 02003200
FFC12283 80000058 0200A050
0101C303 8000005C 0200A040
FE952C23 80000060 00004030
06B60223 80000064 00004020
00208863 80000068 00800280
FE419CE3 8000006C 01800280
0062C0E3 80000070 01800680
8083D063 80000074 00800680
02A4E063 80000078 01800880
00C5F263 8000007C 00800880
801FF0EF 80000080 02210100
3461206F 80000084 02210100
00C280E7 80000088 02412180
ABCDE2B7 8000008C 02118000
12345317 80000090 02080000
00000073 80000094 00040000
0FF0000F 80000098 00040000
1234567B 8000009C 00040000

// ==== all.f ====
hdl/rvDecodePkg.sv
hdl/controlDecoder.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/decodeUnit.sv
sim/decodeUnit_checker.sv
sim/decodeUnitTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f all.f --top-module decodeUnitTb -Mdir obj_dir
	obj_dir/VdecodeUnitTb +verilator+error+limit+100 > $(LOG)
	cat $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
